// File: files.f
logic/gfx_pkg.sv
logic/video_timing.sv
logic/gfx_regs.sv
logic/tile_layer.sv
logic/rom_arbiter.sv
logic/colour_mixer.sv
logic/gfx_top.sv
testbench/gfx_tb.sv

// File: Makefile
# Verilator build for the tilemap graphics block

VERILATOR ?= verilator
FILELIST  ?= files.f
TB_TOP    ?= gfx_tb
RTL_TOP   ?= gfx_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TB_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) \
		--top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	-./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/gfx_tb.sv
// Testbench for the tilemap graphics block
// Random CPU programming, a ROM responder with stalls and a reference pixel model
`default_nettype none

module gfx_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int V_TOTAL = 12;
    localparam int V_VIS   = 8;
    localparam int H_VIS   = 256;
    localparam int FRAME_TIMEOUT = 40000;

    logic        clk;
    logic        rst;
    logic        cs;
    logic        we;
    logic [11:0] addr;
    logic [7:0]  din;
    logic [7:0]  dout;
    logic        irq_n;
    logic        rom_req_valid;
    logic        rom_req_ready;
    logic [12:0] rom_addr;
    logic        rom_rsp_valid;
    logic [15:0] rom_data;
    logic        prog_we;
    logic [4:0]  prog_addr;
    logic [7:0]  prog_data;
    logic [7:0]  pxl_colour;
    logic        pxl_valid;
    logic        hs;
    logic        vs;

    // Model state
    integer      seed;
    logic [7:0]  ram_sh [2][1024];
    logic [7:0]  pal_sh [32];
    logic [7:0]  sx_sh [2];
    logic [7:0]  sy_sh [2];
    logic        en_sh [2];
    logic        check_en;
    int          pix_n;
    int          req_count;
    int          hs_edges;
    int          vs_edges;

    gfx_top #(.V_TOTAL(V_TOTAL), .V_VIS(V_VIS)) uut (
        .clk           ( clk           ),
        .rst           ( rst           ),
        .cs            ( cs            ),
        .we            ( we            ),
        .addr          ( addr          ),
        .din           ( din           ),
        .dout          ( dout          ),
        .irq_n         ( irq_n         ),
        .rom_req_valid ( rom_req_valid ),
        .rom_req_ready ( rom_req_ready ),
        .rom_addr      ( rom_addr      ),
        .rom_rsp_valid ( rom_rsp_valid ),
        .rom_data      ( rom_data      ),
        .prog_we       ( prog_we       ),
        .prog_addr     ( prog_addr     ),
        .prog_data     ( prog_data     ),
        .pxl_colour    ( pxl_colour    ),
        .pxl_valid     ( pxl_valid     ),
        .hs            ( hs            ),
        .vs            ( vs            )
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_failed(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error: %s actual 0x%0h expected 0x%0h", name, actual, expected);
            stop_failed("value mismatch");
        end
    endtask

    // Fixed scramble standing in for the graphics ROM contents
    function automatic logic [15:0] rom_word(input logic [12:0] a);
        logic [15:0] x;
        x = {3'b000, a} * 16'h6b43 + 16'h2f1d;
        return x ^ {x[7:0], x[15:8]};
    endfunction

    function automatic logic [3:0] layer_pixel(input int l, input int v, input int h);
        int          prev_v;
        int          map_y;
        int          k;
        int          col;
        logic [7:0]  code;
        logic [15:0] w;
        // Line v is fetched while the previous line is shown
        prev_v = (v == 0) ? V_TOTAL - 1 : v - 1;
        map_y  = (prev_v + 1 + int'(sy_sh[l])) % 256;
        k      = h + int'(sx_sh[l]) % 8;
        col    = (int'(sx_sh[l]) / 8 + k / 8) % 32;
        code   = ram_sh[l][(map_y / 8) * 32 + col];
        w      = rom_word(13'(l * 4096 + int'(code) * 16 + (map_y % 8) * 2 + (k % 8) / 4));
        return w[15 - 4 * (k % 4) -: 4];
    endfunction

    function automatic logic [7:0] expect_colour(input int v, input int h);
        logic [3:0] a;
        logic [3:0] b;
        logic [4:0] idx;
        a = en_sh[0] ? layer_pixel(0, v, h) : 4'h0;
        b = en_sh[1] ? layer_pixel(1, v, h) : 4'h0;
        if (a != 4'h0) begin
            idx = {1'b0, a};
        end else begin
            idx = (b != 4'h0) ? {1'b1, b} : 5'd0;
        end
        return pal_sh[idx];
    endfunction

    task automatic cpu_write(input logic [11:0] a, input logic [7:0] d);
        @(posedge clk);
        #2;
        cs   = 1'b1;
        we   = 1'b1;
        addr = a;
        din  = d;
        @(posedge clk);
        #2;
        cs = 1'b0;
        we = 1'b0;
    endtask

    task automatic cpu_read(input logic [11:0] a, output logic [7:0] d);
        @(posedge clk);
        #2;
        cs   = 1'b1;
        we   = 1'b0;
        addr = a;
        @(posedge clk);
        #2;
        cs = 1'b0;
        d  = dout;
    endtask

    task automatic pal_write(input logic [4:0] a, input logic [7:0] d);
        @(posedge clk);
        #2;
        prog_we   = 1'b1;
        prog_addr = a;
        prog_data = d;
        pal_sh[a] = d;
        @(posedge clk);
        #2;
        prog_we = 1'b0;
    endtask

    // Waits for the frame IRQ, then acknowledges it
    task automatic ack_frame();
        int n;
        n = 0;
        while (irq_n !== 1'b0) begin
            @(negedge clk);
            n++;
            if (n > FRAME_TIMEOUT) begin
                stop_failed("timeout waiting for the frame interrupt");
            end
        end
        check("pixels per frame", pix_n, 0);
        cpu_write(12'h005, 8'h00);
        check("irq_n", irq_n, 1);
    endtask

    // Reprograms scroll, enables and optionally palette inside vblank
    task automatic next_frame(input logic [7:0] ctrl, input bit new_pal);
        ack_frame();
        for (int l = 0; l < 2; l++) begin
            sx_sh[l] = 8'($random(seed));
            sy_sh[l] = 8'($random(seed));
            cpu_write(12'(2 * l), sx_sh[l]);
            cpu_write(12'(2 * l + 1), sy_sh[l]);
        end
        cpu_write(12'h004, ctrl);
        en_sh[0] = ctrl[1];
        en_sh[1] = ctrl[2];
        if (new_pal) begin
            for (int i = 0; i < 8; i++) begin
                pal_write(5'($random(seed)), 8'($random(seed)));
            end
        end
    endtask

    // Pixel checker in raster order
    initial begin
        int v;
        int h;
        pix_n = 0;
        forever begin
            @(negedge clk);
            if (pxl_valid) begin
                v = pix_n / H_VIS;
                h = pix_n % H_VIS;
                if (check_en) begin
                    check("pxl_colour", pxl_colour, expect_colour(v, h));
                end
                // Syncs belong to the blanking intervals
                check("hs", hs, 0);
                check("vs", vs, 0);
                pix_n = (pix_n + 1) % (H_VIS * V_VIS);
            end
        end
    end

    // Sync pulse counter, one hs per line and one vs per frame
    initial begin
        logic hs_q;
        logic vs_q;
        hs_q     = 1'b0;
        vs_q     = 1'b0;
        hs_edges = 0;
        vs_edges = 0;
        forever begin
            @(negedge clk);
            if (hs && !hs_q) begin
                hs_edges++;
            end
            if (vs && !vs_q) begin
                vs_edges++;
            end
            hs_q = hs;
            vs_q = vs;
        end
    end

    // Graphics ROM responder with random stalls and latency
    initial begin
        bit          outstanding;
        bit          stalled;
        int          rsp_cnt;
        int          low_cnt;
        logic [12:0] held_addr;
        logic [12:0] pend_addr;
        outstanding = 1'b0;
        stalled     = 1'b0;
        rsp_cnt     = 0;
        low_cnt     = 0;
        req_count   = 0;
        forever begin
            @(negedge clk);
            if (stalled) begin
                check("rom_req_valid", rom_req_valid, 1);
                check("rom_addr", rom_addr, held_addr);
            end
            if (outstanding && rom_req_valid) begin
                stop_failed("second ROM request before the response");
            end
            stalled   = rom_req_valid && !rom_req_ready;
            held_addr = rom_addr;
            if (rom_req_valid && rom_req_ready) begin
                outstanding = 1'b1;
                pend_addr   = rom_addr;
                rsp_cnt     = 1 + ($unsigned($random(seed)) % 3);
                req_count++;
            end
            @(posedge clk);
            #2;
            rom_rsp_valid = 1'b0;
            if (outstanding) begin
                if (rsp_cnt == 1) begin
                    rom_rsp_valid = 1'b1;
                    rom_data      = rom_word(pend_addr);
                    outstanding   = 1'b0;
                end else begin
                    rsp_cnt--;
                end
            end
            if (low_cnt > 0) begin
                rom_req_ready = 1'b0;
                low_cnt--;
            end else begin
                rom_req_ready = 1'b1;
                if ($unsigned($random(seed)) % 4 == 0) begin
                    low_cnt = $unsigned($random(seed)) % 3;
                end
            end
        end
    end

    initial begin
        logic [7:0] rd;
        logic [7:0] regs [6];
        int         n;
        seed          = 32'ha4dd_4bac;
        check_en      = 1'b0;
        rst           = 1'b1;
        cs            = 1'b0;
        we            = 1'b0;
        addr          = '0;
        din           = '0;
        prog_we       = 1'b0;
        prog_addr     = '0;
        prog_data     = '0;
        rom_req_ready = 1'b0;
        rom_rsp_valid = 1'b0;
        rom_data      = '0;
        for (int l = 0; l < 2; l++) begin
            sx_sh[l] = '0;
            sy_sh[l] = '0;
            en_sh[l] = 1'b0;
        end
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        check("irq_n", irq_n, 1);
        check("rom_req_valid", rom_req_valid, 0);
        check("pxl_valid", pxl_valid, 0);

        for (int i = 0; i < 32; i++) begin
            pal_write(5'(i), 8'($random(seed)));
        end
        check_en = 1'b1;

        // Tile RAM and register read-back, both layers still off
        for (int l = 0; l < 2; l++) begin
            for (int i = 0; i < 1024; i++) begin
                ram_sh[l][i] = 8'($random(seed));
                cpu_write(12'(12'h400 * (l + 1) + i), ram_sh[l][i]);
            end
        end
        for (int l = 0; l < 2; l++) begin
            for (int i = 0; i < 1024; i++) begin
                cpu_read(12'(12'h400 * (l + 1) + i), rd);
                check(l == 0 ? "tile ram a" : "tile ram b", rd, ram_sh[l][i]);
            end
        end
        for (int i = 0; i < 6; i++) begin
            regs[i] = 8'($random(seed));
        end
        regs[4] = regs[4] & 8'hf8;
        for (int i = 0; i < 6; i++) begin
            cpu_write(12'(i), regs[i]);
        end
        regs[5] = 8'h00;
        for (int i = 0; i < 6; i++) begin
            cpu_read(12'(i), rd);
            check("register", rd, regs[i]);
        end
        for (int i = 0; i < 4; i++) begin
            sx_sh[i / 2] = (i % 2 == 0) ? regs[i] : sx_sh[i / 2];
            sy_sh[i / 2] = (i % 2 == 1) ? regs[i] : sy_sh[i / 2];
        end
        cpu_write(12'h004, 8'h01);

        // IRQ on, then off for longer than a frame
        ack_frame();
        cpu_write(12'h004, 8'h00);
        repeat (16000) begin
            @(negedge clk);
            check("irq_n", irq_n, 1);
        end
        cpu_write(12'h004, 8'h01);

        next_frame(8'h03, 1'b0);
        next_frame(8'h03, 1'b0);
        next_frame(8'h05, 1'b0);
        next_frame(8'h07, 1'b1);
        next_frame(8'h07, 1'b1);

        // Layers off: no ROM traffic for a whole frame
        next_frame(8'h01, 1'b1);
        ack_frame();
        n        = req_count;
        hs_edges = 0;
        vs_edges = 0;
        ack_frame();
        check("rom transfers", req_count, n);
        check("hs pulses per frame", hs_edges, V_TOTAL);
        check("vs pulses per frame", vs_edges, 1);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/gfx_top.sv
// Tilemap graphics block, top level
// Timing, CPU registers, two tile layers, ROM sharing and colour output
`default_nettype none

module gfx_top import gfx_pkg::*; #(
    parameter int H_TOTAL = 320,
    parameter int V_TOTAL = 262,
    parameter int V_VIS   = 224
) (
    input  wire       clk,
    input  wire       rst,
    input  wire       cs,
    input  wire       we,
    input  wire cpu_addr_t addr,
    input  wire byte_t din,
    output byte_t     dout,
    output logic      irq_n,
    output logic      rom_req_valid,
    input  wire       rom_req_ready,
    output rom_addr_t rom_addr,
    input  wire       rom_rsp_valid,
    input  wire rom_word_t rom_data,
    input  wire       prog_we,
    input  wire pal_idx_t prog_addr,
    input  wire colour_t prog_data,
    output colour_t   pxl_colour,
    output logic      pxl_valid,
    output logic      hs,
    output logic      vs
);

    logic      pxl_cen, visible, line_start, vblank_start;
    scan_t     hcount, vcount;
    byte_t     ram_a_rd, ram_b_rd;
    logic      ram_a_we, ram_b_we;
    byte_t     scroll_x_a, scroll_y_a, scroll_x_b, scroll_y_b;
    logic      layer_a_en, layer_b_en;
    logic      req_valid_a, req_ready_a, rsp_valid_a;
    logic      req_valid_b, req_ready_b, rsp_valid_b;
    rom_addr_t req_addr_a, req_addr_b;
    rom_word_t rsp_data;
    tile_pxl_t pxl_a, pxl_b;

    video_timing #(
        .H_TOTAL ( H_TOTAL ),
        .V_TOTAL ( V_TOTAL ),
        .V_VIS   ( V_VIS   )
    ) u_timing (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .pxl_cen      ( pxl_cen      ),
        .hcount       ( hcount       ),
        .vcount       ( vcount       ),
        .visible      ( visible      ),
        .line_start   ( line_start   ),
        .vblank_start ( vblank_start ),
        .hs           ( hs           ),
        .vs           ( vs           )
    );

    gfx_regs u_regs (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .cs           ( cs           ),
        .we           ( we           ),
        .addr         ( addr         ),
        .din          ( din          ),
        .vblank_start ( vblank_start ),
        .ram_a_rd     ( ram_a_rd     ),
        .ram_b_rd     ( ram_b_rd     ),
        .dout         ( dout         ),
        .ram_a_we     ( ram_a_we     ),
        .ram_b_we     ( ram_b_we     ),
        .scroll_x_a   ( scroll_x_a   ),
        .scroll_y_a   ( scroll_y_a   ),
        .scroll_x_b   ( scroll_x_b   ),
        .scroll_y_b   ( scroll_y_b   ),
        .layer_a_en   ( layer_a_en   ),
        .layer_b_en   ( layer_b_en   ),
        .irq_n        ( irq_n        )
    );

    tile_layer #(.LAYER(0), .H_TOTAL(H_TOTAL)) u_layer_a (
        .clk        ( clk         ),
        .rst        ( rst         ),
        .ram_we     ( ram_a_we    ),
        .addr       ( addr        ),
        .din        ( din         ),
        .scroll_x   ( scroll_x_a  ),
        .scroll_y   ( scroll_y_a  ),
        .enable     ( layer_a_en  ),
        .line_start ( line_start  ),
        .vcount     ( vcount      ),
        .hcount     ( hcount      ),
        .pxl_cen    ( pxl_cen     ),
        .req_ready  ( req_ready_a ),
        .rsp_valid  ( rsp_valid_a ),
        .rsp_data   ( rsp_data    ),
        .ram_rd     ( ram_a_rd    ),
        .req_valid  ( req_valid_a ),
        .req_addr   ( req_addr_a  ),
        .pxl        ( pxl_a       )
    );

    tile_layer #(.LAYER(1), .H_TOTAL(H_TOTAL)) u_layer_b (
        .clk        ( clk         ),
        .rst        ( rst         ),
        .ram_we     ( ram_b_we    ),
        .addr       ( addr        ),
        .din        ( din         ),
        .scroll_x   ( scroll_x_b  ),
        .scroll_y   ( scroll_y_b  ),
        .enable     ( layer_b_en  ),
        .line_start ( line_start  ),
        .vcount     ( vcount      ),
        .hcount     ( hcount      ),
        .pxl_cen    ( pxl_cen     ),
        .req_ready  ( req_ready_b ),
        .rsp_valid  ( rsp_valid_b ),
        .rsp_data   ( rsp_data    ),
        .ram_rd     ( ram_b_rd    ),
        .req_valid  ( req_valid_b ),
        .req_addr   ( req_addr_b  ),
        .pxl        ( pxl_b       )
    );

    rom_arbiter u_arbiter (
        .clk           ( clk           ),
        .rst           ( rst           ),
        .req_valid_a   ( req_valid_a   ),
        .req_addr_a    ( req_addr_a    ),
        .req_valid_b   ( req_valid_b   ),
        .req_addr_b    ( req_addr_b    ),
        .rom_req_ready ( rom_req_ready ),
        .rom_rsp_valid ( rom_rsp_valid ),
        .rom_data      ( rom_data      ),
        .req_ready_a   ( req_ready_a   ),
        .rsp_valid_a   ( rsp_valid_a   ),
        .req_ready_b   ( req_ready_b   ),
        .rsp_valid_b   ( rsp_valid_b   ),
        .rsp_data      ( rsp_data      ),
        .rom_req_valid ( rom_req_valid ),
        .rom_addr      ( rom_addr      )
    );

    colour_mixer u_mixer (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .pxl_a      ( pxl_a      ),
        .pxl_b      ( pxl_b      ),
        .visible    ( visible    ),
        .pxl_cen    ( pxl_cen    ),
        .prog_we    ( prog_we    ),
        .prog_addr  ( prog_addr  ),
        .prog_data  ( prog_data  ),
        .pxl_colour ( pxl_colour ),
        .pxl_valid  ( pxl_valid  )
    );

endmodule

`default_nettype wire

// File: logic/colour_mixer.sv
// Layer priority and palette lookup
// Layer A covers B unless transparent, result goes through a 32-entry palette
`default_nettype none

module colour_mixer import gfx_pkg::*; (
    input  wire       clk,
    input  wire       rst,
    input  wire tile_pxl_t pxl_a,
    input  wire tile_pxl_t pxl_b,
    input  wire       visible,
    input  wire       pxl_cen,
    input  wire       prog_we,
    input  wire pal_idx_t prog_addr,
    input  wire colour_t prog_data,
    output colour_t   pxl_colour,
    output logic      pxl_valid
);

    colour_t  pal_ram [0:31];
    pal_idx_t pal_idx;
    logic     vis_d;
    logic     cen_d;

    always_ff @(posedge clk) begin
        if (prog_we) begin
            pal_ram[prog_addr] <= prog_data;
        end
    end

    // Both transparent falls through to entry 0
    assign pal_idx = (pxl_a != '0) ? {1'b0, pxl_a} : {pxl_b != '0, pxl_b};

    // Line buffer read lands one clk after pxl_cen
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vis_d     <= 1'b0;
            cen_d     <= 1'b0;
            pxl_valid <= 1'b0;
        end else begin
            vis_d     <= visible;
            cen_d     <= pxl_cen;
            pxl_valid <= cen_d && vis_d;
        end
    end

    always_ff @(posedge clk) begin
        if (cen_d) begin
            pxl_colour <= pal_ram[pal_idx];
        end
    end

endmodule

`default_nettype wire

// File: logic/rom_arbiter.sv
// Graphics ROM port sharing between the two layers
// Layer A wins ties, and one transfer is in flight at a time
`default_nettype none

module rom_arbiter import gfx_pkg::*; (
    input  wire       clk,
    input  wire       rst,
    input  wire       req_valid_a,
    input  wire rom_addr_t req_addr_a,
    input  wire       req_valid_b,
    input  wire rom_addr_t req_addr_b,
    input  wire       rom_req_ready,
    input  wire       rom_rsp_valid,
    input  wire rom_word_t rom_data,
    output logic      req_ready_a,
    output logic      rsp_valid_a,
    output logic      req_ready_b,
    output logic      rsp_valid_b,
    output rom_word_t rsp_data,
    output logic      rom_req_valid,
    output rom_addr_t rom_addr
);

    typedef enum logic [1:0] {IDLE, GRANT_A, GRANT_B, WAIT_RSP} arb_state_t;

    arb_state_t state;
    logic       owner_b;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            owner_b <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (req_valid_a) begin
                        state   <= GRANT_A;
                        owner_b <= 1'b0;
                    end else if (req_valid_b) begin
                        state   <= GRANT_B;
                        owner_b <= 1'b1;
                    end
                end
                GRANT_A, GRANT_B: begin
                    if (rom_req_ready) begin
                        state <= WAIT_RSP;
                    end
                end
                WAIT_RSP: begin
                    if (rom_rsp_valid) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign rom_req_valid = state == GRANT_A || state == GRANT_B;
    assign rom_addr      = owner_b ? req_addr_b : req_addr_a;
    assign req_ready_a   = state == GRANT_A && rom_req_ready;
    assign req_ready_b   = state == GRANT_B && rom_req_ready;

    // Strobe goes back to whoever owns the transfer
    assign rsp_valid_a = state == WAIT_RSP && rom_rsp_valid && !owner_b;
    assign rsp_valid_b = state == WAIT_RSP && rom_rsp_valid && owner_b;
    assign rsp_data    = rom_data;

    a_no_stray_rsp: assert property (@(posedge clk) disable iff (rst)
        state == IDLE |-> !rom_rsp_valid)
        else $error("ROM response with no transfer outstanding");

endmodule

`default_nettype wire

// File: logic/tile_layer.sv
// One scrolling 8x8 tile layer
// 32x32 tile map RAM, per-line ROM fetch and a double line buffer.
// The back buffer is filled during the line before it is shown.
`default_nettype none

module tile_layer import gfx_pkg::*; #(
    parameter int LAYER   = 0,
    parameter int H_TOTAL = 320
) (
    input  wire       clk,
    input  wire       rst,
    input  wire       ram_we,
    input  wire cpu_addr_t addr,
    input  wire byte_t din,
    input  wire byte_t scroll_x,
    input  wire byte_t scroll_y,
    input  wire       enable,
    input  wire       line_start,
    input  wire scan_t vcount,
    input  wire scan_t hcount,
    input  wire       pxl_cen,
    input  wire       req_ready,
    input  wire       rsp_valid,
    input  wire rom_word_t rsp_data,
    output byte_t     ram_rd,
    output logic      req_valid,
    output rom_addr_t req_addr,
    output tile_pxl_t pxl
);

    typedef enum logic [1:0] {IDLE, READ_CODE, REQUEST, WAIT_DATA} fetch_state_t;

    fetch_state_t fetch_state;
    byte_t        tile_ram [0:1023];
    tile_pxl_t    line_buf [0:511];
    byte_t        code_q;
    byte_t        map_y;
    logic [2:0]   fine_x;
    logic [4:0]   col_base;
    logic [5:0]   tile_cnt;
    logic         half;
    logic         bank;
    logic [1:0]   bank_en;
    logic         rd_bank;
    logic [9:0]   fetch_addr;
    logic [9:0]   wr_base;
    logic [9:0]   wr_x [4];

    assign fetch_addr = {map_y[7:3], col_base + tile_cnt[4:0]};
    assign ram_rd     = tile_ram[addr[9:0]];

    always_ff @(posedge clk) begin
        if (ram_we) begin
            tile_ram[addr[9:0]] <= din;
        end
        // Code held for the whole tile so req_addr cannot move
        if (fetch_state == READ_CODE) begin
            code_q <= tile_ram[fetch_addr];
        end
    end

    assign req_valid = fetch_state == REQUEST;
    assign req_addr  = {1'(LAYER), code_q, map_y[2:0], half};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fetch_state <= IDLE;
            bank        <= 1'b0;
            bank_en     <= '0;
            map_y       <= '0;
            fine_x      <= '0;
            col_base    <= '0;
            tile_cnt    <= '0;
            half        <= 1'b0;
        end else if (line_start) begin
            bank          <= ~bank;
            bank_en[~bank] <= enable;
            // Fetch for the line after this one
            map_y       <= vcount[7:0] + 8'd1 + scroll_y;
            fine_x      <= scroll_x[2:0];
            col_base    <= scroll_x[7:3];
            tile_cnt    <= '0;
            half        <= 1'b0;
            fetch_state <= enable ? READ_CODE : IDLE;
        end else begin
            case (fetch_state)
                READ_CODE: fetch_state <= REQUEST;
                REQUEST: begin
                    if (req_ready) begin
                        fetch_state <= WAIT_DATA;
                    end
                end
                WAIT_DATA: begin
                    if (rsp_valid) begin
                        half <= ~half;
                        if (!half) begin
                            fetch_state <= REQUEST;
                        end else if (tile_cnt == 6'd32) begin
                            fetch_state <= IDLE;
                        end else begin
                            tile_cnt    <= tile_cnt + 1'b1;
                            fetch_state <= READ_CODE;
                        end
                    end
                end
                default: fetch_state <= IDLE;
            endcase
        end
    end

    // Screen x of each nibble, shifted left by the fine scroll
    assign wr_base = {1'b0, tile_cnt, half, 2'b00} - {7'd0, fine_x};
    for (genvar i = 0; i < 4; i++) begin : g_wr_x
        assign wr_x[i] = wr_base + 10'(i);
    end

    always_ff @(posedge clk) begin
        if (fetch_state == WAIT_DATA && rsp_valid) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_x[i][9:8] == 2'b00) begin
                    line_buf[{bank, wr_x[i][7:0]}] <= rsp_data[15 - 4*i -: 4];
                end
            end
        end
    end

    // Front bank flips at line_start itself, not a clock later
    assign rd_bank = line_start ? bank : ~bank;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pxl <= '0;
        end else if (pxl_cen) begin
            pxl <= bank_en[rd_bank] ? line_buf[{rd_bank, hcount[7:0]}] : '0;
        end
    end

    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        req_valid && !req_ready |=> req_valid && $stable(req_addr))
        else $error("layer %0d ROM request changed while stalled", LAYER);

    // Last pixel slot of a line, PXL_DIV clocks ahead of line_start
    a_fetch_done: assert property (@(posedge clk) disable iff (rst)
        pxl_cen && hcount == scan_t'(H_TOTAL - 1) |-> ##PXL_DIV fetch_state == IDLE)
        else $error("layer %0d line fetch overran the line", LAYER);

endmodule

`default_nettype wire

// File: logic/gfx_regs.sv
// CPU interface of the graphics block
// Window decode, control registers, registered read-back and frame IRQ
`default_nettype none

module gfx_regs import gfx_pkg::*; (
    input  wire       clk,
    input  wire       rst,
    input  wire       cs,
    input  wire       we,
    input  wire cpu_addr_t addr,
    input  wire byte_t din,
    input  wire       vblank_start,
    input  wire byte_t ram_a_rd,
    input  wire byte_t ram_b_rd,
    output byte_t     dout,
    output logic      ram_a_we,
    output logic      ram_b_we,
    output byte_t     scroll_x_a,
    output byte_t     scroll_y_a,
    output byte_t     scroll_x_b,
    output byte_t     scroll_y_b,
    output logic      layer_a_en,
    output logic      layer_b_en,
    output logic      irq_n
);

    byte_t ctrl;
    byte_t rd_byte;
    logic  reg_sel;
    logic  ram_a_sel;
    logic  ram_b_sel;
    logic  reg_wr;

    assign reg_sel   = cs && addr[11:10] == WIN_REGS && addr[9:3] == '0;
    assign ram_a_sel = cs && addr[11:10] == WIN_RAM_A;
    assign ram_b_sel = cs && addr[11:10] == WIN_RAM_B;
    assign reg_wr    = reg_sel && we;
    assign ram_a_we  = ram_a_sel && we;
    assign ram_b_we  = ram_b_sel && we;

    assign layer_a_en = ctrl[CTRL_A_EN];
    assign layer_b_en = ctrl[CTRL_B_EN];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scroll_x_a <= '0;
            scroll_y_a <= '0;
            scroll_x_b <= '0;
            scroll_y_b <= '0;
            ctrl       <= '0;
        end else if (reg_wr) begin
            case (addr[2:0])
                REG_SCROLL_X_A: scroll_x_a <= din;
                REG_SCROLL_Y_A: scroll_y_a <= din;
                REG_SCROLL_X_B: scroll_x_b <= din;
                REG_SCROLL_Y_B: scroll_y_b <= din;
                REG_CTRL:       ctrl       <= din;
                default: ;
            endcase
        end
    end

    // IRQ ack and unmapped offsets read as zero
    always_comb begin
        rd_byte = '0;
        if (reg_sel) begin
            case (addr[2:0])
                REG_SCROLL_X_A: rd_byte = scroll_x_a;
                REG_SCROLL_Y_A: rd_byte = scroll_y_a;
                REG_SCROLL_X_B: rd_byte = scroll_x_b;
                REG_SCROLL_Y_B: rd_byte = scroll_y_b;
                REG_CTRL:       rd_byte = ctrl;
                default:        rd_byte = '0;
            endcase
        end else if (ram_a_sel) begin
            rd_byte = ram_a_rd;
        end else if (ram_b_sel) begin
            rd_byte = ram_b_rd;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dout  <= '0;
            irq_n <= 1'b1;
        end else begin
            if (cs && !we) begin
                dout <= rd_byte;
            end
            // A new frame wins over a simultaneous ack
            if (reg_wr && addr[2:0] == REG_IRQ_ACK) begin
                irq_n <= 1'b1;
            end
            if (vblank_start && ctrl[CTRL_IRQ_EN]) begin
                irq_n <= 1'b0;
            end
        end
    end

    a_one_ram_we: assert property (@(posedge clk) disable iff (rst)
        !(ram_a_we && ram_b_we))
        else $error("both tile RAM write enables high");

endmodule

`default_nettype wire

// File: logic/video_timing.sv
// Video timing generator
// Pixel clock enable, raster counters, syncs and line/frame event pulses
`default_nettype none

module video_timing import gfx_pkg::*; #(
    parameter int H_TOTAL = 320,
    parameter int V_TOTAL = 262,
    parameter int V_VIS   = 224
) (
    input  wire  clk,
    input  wire  rst,
    output logic pxl_cen,
    output scan_t hcount,
    output scan_t vcount,
    output logic visible,
    output logic line_start,
    output logic vblank_start,
    output logic hs,
    output logic vs
);

    localparam int DIV_W = $clog2(PXL_DIV);

    logic [DIV_W-1:0] div_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            pxl_cen <= 1'b0;
            hcount  <= '0;
            vcount  <= '0;
        end else begin
            div_cnt <= (div_cnt == DIV_W'(PXL_DIV - 1)) ? '0 : div_cnt + 1'b1;
            pxl_cen <= div_cnt == DIV_W'(PXL_DIV - 1);
            // Counters name the pixel of the current pxl_cen slot
            if (pxl_cen) begin
                if (hcount == scan_t'(H_TOTAL - 1)) begin
                    hcount <= '0;
                    vcount <= (vcount == scan_t'(V_TOTAL - 1)) ? '0 : vcount + 1'b1;
                end else begin
                    hcount <= hcount + 1'b1;
                end
            end
        end
    end

    assign visible      = hcount < scan_t'(H_VIS) && vcount < scan_t'(V_VIS);
    assign line_start   = pxl_cen && hcount == '0;
    assign vblank_start = line_start && vcount == scan_t'(V_VIS);

    // Syncs sit inside the blanking intervals
    assign hs = hcount >= scan_t'(H_VIS + 16) && hcount < scan_t'(H_VIS + 48);
    assign vs = vcount >= scan_t'(V_VIS + 1) && vcount < scan_t'(V_VIS + 3);

endmodule

`default_nettype wire

// File: logic/gfx_pkg.sv
// Tilemap graphics block, shared definitions
// Vector types, CPU register map and the pixel clock divide
`default_nettype none

package gfx_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [11:0] cpu_addr_t;
    // Layer bit, tile code, tile row, half
    typedef logic [12:0] rom_addr_t;
    // Four pixels, leftmost in the top nibble
    typedef logic [15:0] rom_word_t;
    typedef logic [3:0]  tile_pxl_t;
    typedef logic [4:0]  pal_idx_t;
    typedef logic [7:0]  colour_t;
    typedef logic [8:0]  scan_t;

    // Register offsets inside the 0x000-0x007 window
    localparam logic [2:0] REG_SCROLL_X_A = 3'd0;
    localparam logic [2:0] REG_SCROLL_Y_A = 3'd1;
    localparam logic [2:0] REG_SCROLL_X_B = 3'd2;
    localparam logic [2:0] REG_SCROLL_Y_B = 3'd3;
    localparam logic [2:0] REG_CTRL       = 3'd4;
    localparam logic [2:0] REG_IRQ_ACK    = 3'd5;

    // REG_CTRL bits
    localparam int CTRL_IRQ_EN = 0;
    localparam int CTRL_A_EN   = 1;
    localparam int CTRL_B_EN   = 2;

    // Windows decoded on addr[11:10]
    localparam logic [1:0] WIN_REGS  = 2'b00;
    localparam logic [1:0] WIN_RAM_A = 2'b01;
    localparam logic [1:0] WIN_RAM_B = 2'b10;

    localparam int PXL_DIV = 4;
    localparam int H_VIS   = 256;

endpackage

`default_nettype wire
